// ==== Bender.yml ====
package:
  name: adc_acq

sources:
  - files:
      - common/acq_pkg.sv
      - common/sample_pkg.sv
      - source/acq_cmd_decode.sv
      - capture/sample_source.sv
      - capture/circ_buf_writer.sv
      - source/buf_readout.sv
      - source/adc_acq_top.sv
  - target: simulation
    files:
      - tb/adc_acq_assert.sv
      - tb/adc_acq_tb.sv

// ==== all.f ====
common/acq_pkg.sv
common/sample_pkg.sv
source/acq_cmd_decode.sv
capture/sample_source.sv
capture/circ_buf_writer.sv
source/buf_readout.sv
source/adc_acq_top.sv
tb/adc_acq_assert.sv
tb/adc_acq_tb.sv

// ==== capture/circ_buf_writer.sv ====
`timescale 1ns/1ns

module circ_buf_writer
    import acq_pkg::*;
    import sample_pkg::*;
(
    input  logic              adc_clk,
    input  logic              rst,
    input  sample_u           smp,             // word to store this cycle
    input  logic              arm,             // start a new acquisition
    input  logic              trig,            // single-cycle trigger pulse
    input  acq_cfg_t          cfg,
    input  logic [buf_aw-1:0] mem_raddr,       // read address from the readout
    output sample_u           mem_q,           // registered read data
    output logic              armed,           // writing in progress
    output logic              done,            // acquisition finished
    output logic [buf_aw-1:0] trig_addr        // address written in the trigger cycle
);

    logic [sample_w-1:0] mem [buf_depth];      // circular buffer, no reset

    logic [buf_aw-1:0] wr_addr;                // wraps at buf_depth
    logic              trig_seen;              // first trigger already latched
    logic [buf_aw-1:0] post_cnt;               // post-trigger writes still to go

    //////////////////////////////
    // memory
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (armed) begin
            mem[wr_addr] <= smp;               // one word per cycle while armed
        end
        mem_q <= mem[mem_raddr];               // read before write on a collision
    end

    //////////////////////////////
    // write control
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_addr   <= '0;
            armed     <= 1'b0;
            done      <= 1'b0;
            trig_seen <= 1'b0;
            post_cnt  <= '0;
            trig_addr <= '0;
        end else if (arm) begin
            // fresh acquisition from address 0
            wr_addr   <= '0;
            armed     <= 1'b1;
            done      <= 1'b0;
            trig_seen <= 1'b0;
        end else if (armed) begin
            wr_addr <= wr_addr + 1'b1;         // natural wrap
            if (!trig_seen) begin
                if (trig) begin
                    trig_seen <= 1'b1;
                    trig_addr <= wr_addr;      // the word going in right now
                    post_cnt  <= cfg.post_len;
                    if (cfg.post_len == '0) begin
                        // nothing to add after the trigger
                        armed <= 1'b0;
                        done  <= 1'b1;
                    end
                end
            end else if (post_cnt == buf_aw'(1)) begin
                // last post-trigger word is written this cycle
                armed <= 1'b0;
                done  <= 1'b1;
            end else begin
                post_cnt <= post_cnt - 1'b1;   // later trigs are ignored here
            end
        end
    end

endmodule

// ==== capture/sample_source.sv ====
`timescale 1ns/1ns

module sample_source
    import acq_pkg::*;
    import sample_pkg::*;
(
    input  logic     adc_clk,
    input  logic     rst,
    input  sample_u  adc_dat,                  // widened SDR pair from the front end
    input  acq_cfg_t cfg,
    input  logic     armed,                    // buffer is being written
    input  logic     trig,                     // single-cycle trigger pulse
    output sample_u  smp                       // word to be written into the buffer
);

    logic [smp_dw-1:0] cnt;                    // dummy counter
    logic [smp_dw-1:0] cnt_nxt;                // value the counter takes at the next edge
    sample_u           dmy_word;               // counter formatted as a sample word

    //////////////////////////////
    // dummy counter
    //////////////////////////////

    always_comb begin
        if (cfg.dummy_reset_mode && trig) begin
            cnt_nxt = '0;                      // restart so the first post-trig word is 0
        end else if (armed && cfg.use_dummy) begin
            cnt_nxt = cnt + 1'b1;              // one step per written word
        end else begin
            cnt_nxt = cnt;                     // hold
        end
    end

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_nxt;
        end
    end

    // smp is loaded from cnt_nxt so the word written after
    // the trigger cycle already carries the cleared count
    always_comb begin
        dmy_word.dmy.zero0   = 1'b0;           // no over-range in test mode
        dmy_word.dmy.cnt     = cnt_nxt;
        dmy_word.dmy.zero1   = 1'b0;
        dmy_word.dmy.cnt_inv = ~cnt_nxt;       // inverted copy for the integrity check
    end

    //////////////////////////////
    // sample register
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (cfg.use_dummy) begin
            smp <= dmy_word;                   // test pattern
        end else begin
            smp <= adc_dat;                    // real ADC pair, passed as is
        end
    end

endmodule

// ==== common/acq_pkg.sv ====
package acq_pkg;

    //////////////////////////////
    // buffer geometry
    //////////////////////////////
    localparam int buf_aw    = 6;              // write / read address width
    localparam int buf_depth = 1 << buf_aw;    // 64 words in the circular buffer

    //////////////////////////////
    // host command word
    //////////////////////////////
    localparam int cmd_arg_w = 8;              // argument field of a command

    // bit positions inside the op_mode argument
    localparam int mode_dummy_bit = 0;         // select dummy counter as data source
    localparam int mode_rst_bit   = 1;         // clear dummy counter on trigger

    typedef enum logic [1:0] {
        op_mode = 2'd0,                        // load mode bits
        op_post = 2'd1,                        // load post-trigger length
        op_arm  = 2'd2,                        // start a new acquisition
        op_read = 2'd3                         // read one word relative to trig_addr
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t              op;              // what to do
        logic [cmd_arg_w-1:0] arg;             // meaning depends on op
    } acq_cmd_t;                               // 10 bits

    //////////////////////////////
    // held configuration
    //////////////////////////////
    typedef struct packed {
        logic              use_dummy;          // test mode
        logic              dummy_reset_mode;   // restart count at each trigger
        logic [buf_aw-1:0] post_len;           // words written after the trigger
    } acq_cfg_t;                               // 8 bits

    // everything the host has not set yet reads as zero
    localparam acq_cfg_t cfg_reset = '0;

endpackage

// ==== common/sample_pkg.sv ====
package sample_pkg;

    localparam int smp_dw   = 12;              // one ADC sample
    localparam int sample_w = 2 * (smp_dw + 1); // two samples plus their over-range bits

    // word as delivered by the ADC front end
    typedef struct packed {
        logic [smp_dw-1:0] s1;                 // bits 25:14 second sample
        logic              ovr1;               // bit 13
        logic [smp_dw-1:0] s0;                 // bits 12:1 first sample
        logic              ovr0;               // bit 0
    } adc_pair_t;

    // same bits when the dummy counter feeds the buffer
    typedef struct packed {
        logic [smp_dw-1:0] cnt_inv;            // complement of cnt
        logic              zero1;              // always 0 in test mode
        logic [smp_dw-1:0] cnt;                // counter value
        logic              zero0;              // always 0 in test mode
    } dmy_pair_t;

    typedef union packed {
        adc_pair_t adc;
        dmy_pair_t dmy;
    } sample_u;                                // 26 bits

    // one readout result
    typedef struct packed {
        sample_u word;                         // raw buffer contents
        logic    any_ovr;                      // either over-range bit set
        logic    pattern_err;                  // test-mode integrity failure
    } rd_result_t;                             // 28 bits

endpackage

// ==== source/acq_cmd_decode.sv ====
`timescale 1ns/1ns

module acq_cmd_decode
    import acq_pkg::*;
(
    input  logic              adc_clk,
    input  logic              rst,
    input  logic              cmd_valid,       // single-cycle command strobe
    input  acq_cmd_t          cmd,
    output acq_cfg_t          cfg,             // held configuration
    output logic              arm,             // one-cycle arm pulse
    output logic              rd_req,          // one-cycle read pulse
    output logic [buf_aw-1:0] rd_off           // offset from trig_addr, valid with rd_req
);

    //////////////////////////////
    // control registers
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            cfg    <= cfg_reset;
            arm    <= 1'b0;
            rd_req <= 1'b0;
        end else begin
            arm    <= 1'b0;                    // strobes last one cycle
            rd_req <= 1'b0;
            if (cmd_valid) begin
                case (cmd.op)
                    op_mode: begin
                        cfg.use_dummy        <= cmd.arg[mode_dummy_bit];
                        cfg.dummy_reset_mode <= cmd.arg[mode_rst_bit];
                    end
                    op_post: begin
                        cfg.post_len <= cmd.arg[buf_aw-1:0];
                    end
                    op_arm: begin
                        arm <= 1'b1;
                    end
                    op_read: begin
                        rd_req <= 1'b1;
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // read offset
    //////////////////////////////

    // only meaningful while rd_req is high
    always_ff @(posedge adc_clk) begin
        if (cmd_valid && cmd.op == op_read) begin
            rd_off <= cmd.arg[buf_aw-1:0];     // low bits of the argument
        end
    end

endmodule

// ==== source/adc_acq_top.sv ====
`timescale 1ns/1ns

module adc_acq_top
    import acq_pkg::*;
    import sample_pkg::*;
(
    input  logic              adc_clk,
    input  logic              rst,
    input  sample_u           adc_dat,         // new sample pair every cycle
    input  logic              trig,
    input  logic              cmd_valid,
    input  acq_cmd_t          cmd,
    output logic              armed,
    output logic              done,
    output logic [buf_aw-1:0] trig_addr,
    output logic              rd_valid,
    output rd_result_t        rd_res
);

    acq_cfg_t          cfg;                    // held mode and post length
    logic              arm;
    logic              rd_req;
    logic [buf_aw-1:0] rd_off;
    sample_u           smp;                    // registered source word
    sample_u           mem_q;
    logic [buf_aw-1:0] mem_raddr;

    //////////////////////////////
    // host side
    //////////////////////////////

    acq_cmd_decode cmd_decode_i (
        .adc_clk   (adc_clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cfg       (cfg),
        .arm       (arm),
        .rd_req    (rd_req),
        .rd_off    (rd_off)
    );

    //////////////////////////////
    // capture path
    //////////////////////////////

    sample_source sample_source_i (
        .adc_clk (adc_clk),
        .rst     (rst),
        .adc_dat (adc_dat),
        .cfg     (cfg),
        .armed   (armed),
        .trig    (trig),
        .smp     (smp)
    );

    circ_buf_writer circ_buf_writer_i (
        .adc_clk   (adc_clk),
        .rst       (rst),
        .smp       (smp),
        .arm       (arm),
        .trig      (trig),
        .cfg       (cfg),
        .mem_raddr (mem_raddr),
        .mem_q     (mem_q),
        .armed     (armed),
        .done      (done),
        .trig_addr (trig_addr)
    );

    // readout shares the buffer read port
    buf_readout buf_readout_i (
        .adc_clk   (adc_clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_off    (rd_off),
        .trig_addr (trig_addr),
        .use_dummy (cfg.use_dummy),
        .mem_q     (mem_q),
        .mem_raddr (mem_raddr),
        .rd_valid  (rd_valid),
        .rd_res    (rd_res)
    );

endmodule

// ==== source/buf_readout.sv ====
`timescale 1ns/1ns

module buf_readout
    import acq_pkg::*;
    import sample_pkg::*;
(
    input  logic              adc_clk,
    input  logic              rst,
    input  logic              rd_req,          // one-cycle read request
    input  logic [buf_aw-1:0] rd_off,          // offset from the trigger word
    input  logic [buf_aw-1:0] trig_addr,
    input  logic              use_dummy,       // test mode enables the pattern check
    input  sample_u           mem_q,           // registered memory output
    output logic [buf_aw-1:0] mem_raddr,       // absolute buffer address
    output logic              rd_valid,        // one cycle wide, two after rd_req
    output rd_result_t        rd_res
);

    logic [1:0] vld_q;                         // [0] address stage, [1] data stage

    //////////////////////////////
    // address and valid pipe
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rd_req) begin
            mem_raddr <= trig_addr + rd_off;   // wraps around the buffer end
        end
    end

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], rd_req};       // back-to-back reads just flow through
        end
    end

    assign rd_valid = vld_q[1];

    //////////////////////////////
    // word decode
    //////////////////////////////

    always_comb begin
        rd_res.word    = mem_q;
        rd_res.any_ovr = mem_q.adc.ovr0 | mem_q.adc.ovr1;
        // upper field must mirror the counter in test mode
        rd_res.pattern_err = use_dummy && (mem_q.dmy.cnt_inv != ~mem_q.dmy.cnt);
    end

endmodule

// ==== tb/adc_acq_assert.sv ====
`timescale 1ns/1ns

module adc_acq_assert
    import acq_pkg::*;
(
    input logic     adc_clk,
    input logic     rst,
    input logic     cmd_valid,
    input acq_cmd_t cmd,
    input logic     armed,
    input logic     done,
    input logic     rd_valid
);

    //////////////////////////////
    // control output rules
    //////////////////////////////

    // an acquisition is either running or finished
    armed_done_excl: assert property (@(posedge adc_clk) disable iff (rst)
        !(armed && done))
        else $error("armed and done high together");

    // decode, address and data stage
    read_latency: assert property (@(posedge adc_clk) disable iff (rst)
        (cmd_valid && cmd.op == op_read) |-> ##3 rd_valid)
        else $error("rd_valid missing 3 cycles after read command");

    reset_state: assert property (@(posedge adc_clk)
        rst |=> (!armed && !done && !rd_valid))
        else $error("outputs not cleared by reset");

endmodule

bind adc_acq_top adc_acq_assert assert_i (.*);

// ==== tb/adc_acq_tb.sv ====
`timescale 1ns/1ns

module adc_acq_tb
    import acq_pkg::*;
    import sample_pkg::*;
;

    typedef struct packed {
        logic [3:0]          test;             // test number for the summary lines
        logic                cv;               // issue a command in this step
        cmd_op_t             op;
        logic [7:0]          arg;
        logic                tg;               // trigger pulse
        logic [7:0]          idle;             // quiet cycles after the step
        logic                wait_done;        // hold until done rises
        logic [1:0]          chk;              // 1 word from table, 2 word from model
        logic [sample_w-1:0] exp;
    } step_t;

    logic       adc_clk;
    logic       rst;
    sample_u    adc_dat;
    logic       trig;
    logic       cmd_valid;
    acq_cmd_t   cmd;
    logic       armed;
    logic       done;
    logic [buf_aw-1:0] trig_addr;
    logic       rd_valid;
    rd_result_t rd_res;

    step_t      tbl[$];                        // stimulus table
    rd_result_t exp_q[$];                      // expected read results, in order
    int         iss_q[$];                      // cycle of each read command
    int         cyc = 0;
    int         timeout_lim = 0;
    int         checks = 0;
    int         errors = 0;
    int         test_err = 0;

    // reference model of the buffer writer
    logic [sample_w-1:0] m_mem [buf_depth];
    sample_u           m_smp = '0;             // word registered one cycle before its write
    logic              m_arm_q = 0;
    logic              m_armed = 0;
    logic              m_done = 0;
    logic              m_tseen = 0;
    logic              m_dummy = 0;
    logic [buf_aw-1:0] m_wa = '0;
    logic [buf_aw-1:0] m_left = '0;            // writes still owed after the trigger
    logic [buf_aw-1:0] m_taddr = '0;
    logic [buf_aw-1:0] m_post = '0;

    adc_acq_top dut_i (.*);

    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;         // 10 ns period
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // fields from bit 25 down to bit 0
    function automatic logic [sample_w-1:0] dummy_word(input logic [smp_dw-1:0] c);
        return {~c, 1'b0, c, 1'b0};
    endfunction

    task automatic add_step(input int t, input logic cv, input cmd_op_t op, input int arg,
                            input logic tg, input int idle, input logic wd,
                            input int chk, input sample_u exp);
        step_t s;
        s = '{t, cv, op, arg, tg, idle, wd, chk, exp};
        tbl.push_back(s);
    endtask

    // one clock edge as seen by the writer rules
    task automatic model_update(input logic cv, input cmd_op_t op, input logic [7:0] arg,
                                input logic tg, input sample_u d);
        if (m_armed) m_mem[m_wa] = m_smp;      // write with the pre-edge address
        if (m_arm_q) begin
            m_armed = 1;
            m_done  = 0;
            m_tseen = 0;
            m_wa    = '0;
        end else if (m_armed) begin
            if (!m_tseen && tg) begin
                m_tseen = 1;
                m_taddr = m_wa;
                m_left  = m_post;
            end else if (m_tseen) begin
                m_left = m_left - 1'b1;
            end
            if (m_tseen && m_left == '0) begin
                m_armed = 0;
                m_done  = 1;
            end
            m_wa = m_wa + 1'b1;
        end
        m_smp   = d;
        m_arm_q = cv && op == op_arm;
        if (cv && op == op_post) m_post = arg[buf_aw-1:0];
        if (cv && op == op_mode) m_dummy = arg[mode_dummy_bit];
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_cycle(input logic cv, input cmd_op_t op, input logic [7:0] arg,
                             input logic tg, input int chk, input sample_u exp);
        sample_u             d;
        logic [sample_w-1:0] w;
        rd_result_t          r;
        logic [buf_aw-1:0]   a;
        d         = $urandom;
        adc_dat   = d;
        trig      = tg;
        cmd_valid = cv;
        cmd.op    = op;
        cmd.arg   = arg;
        if (cv && op == op_read) begin
            a = m_taddr + arg[buf_aw-1:0];     // wraps at the buffer end
            w = (chk == 1) ? exp : m_mem[a];
            r.word        = w;
            r.any_ovr     = w[0] | w[13];      // ovr0 and ovr1 positions
            // in test mode bits 25:14 must be the complement of bits 12:1
            r.pattern_err = m_dummy && ((w[25:14] ^ w[12:1]) != '1);
            exp_q.push_back(r);
            iss_q.push_back(cyc);
        end
        @(posedge adc_clk);
        model_update(cv, op, arg, tg, d);
        #1;
        check_val("armed", armed, m_armed);
        check_val("done", done, m_done);
        check_val("trig_addr", trig_addr, m_taddr);
    endtask

    task automatic finish_test(input int t);
        while (exp_q.size() > 0) run_cycle(0, op_mode, 0, 0, 0, '0);  // drain reads
        $display("test %0d finished, %0d errors", t, test_err);
        test_err = 0;
    endtask

    //////////////////////////////
    // watchdog and read monitor
    //////////////////////////////

    always @(posedge adc_clk) begin
        cyc++;
        if (timeout_lim > 0 && cyc > timeout_lim) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(negedge adc_clk) begin
        if (!rst && rd_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                test_err++;
                $display("rd_valid came with no read pending");
            end else begin
                check_val("rd_valid cycle", cyc, iss_q.pop_front() + 3);
                check_val("rd_res.word", rd_res.word, exp_q[0].word);
                check_val("rd_res.any_ovr", rd_res.any_ovr, exp_q[0].any_ovr);
                check_val("rd_res.pattern_err", rd_res.pattern_err, exp_q[0].pattern_err);
                void'(exp_q.pop_front());
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int cur;
        int offs[7];
        void'($urandom(32'h705fe1d7));
        rst       = 1'b1;
        adc_dat   = '0;
        trig      = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;

        // test 1 dummy capture up to done, test 2 its readback
        add_step(1, 1, op_mode, 3, 0, 2, 0, 0, '0);
        add_step(1, 1, op_post, 8, 0, 2, 0, 0, '0);
        add_step(1, 1, op_arm, 0, 0, 20, 0, 0, '0);
        add_step(1, 0, op_mode, 0, 1, 0, 1, 0, '0);
        for (int d = 1; d <= 8; d++) add_step(2, 1, op_read, d, 0, 1, 0, 1, dummy_word(d - 1));
        // test 3 random ADC words, wrapping offsets
        add_step(3, 1, op_mode, 0, 0, 2, 0, 0, '0);
        add_step(3, 1, op_post, 20, 0, 2, 0, 0, '0);
        add_step(3, 1, op_arm, 0, 0, 70, 0, 0, '0);
        add_step(3, 0, op_mode, 0, 1, 0, 1, 0, '0);
        offs = '{0, 1, 7, 20, 30, 44, 63};
        foreach (offs[k]) add_step(3, 1, op_read, offs[k], 0, 2, 0, 2, '0);
        // test 4 second trigger ignored, back-to-back reads
        add_step(4, 1, op_post, 10, 0, 2, 0, 0, '0);
        add_step(4, 1, op_arm, 0, 0, 10, 0, 0, '0);
        add_step(4, 0, op_mode, 0, 1, 3, 0, 0, '0);
        add_step(4, 0, op_mode, 0, 1, 0, 1, 0, '0);
        for (int d = 0; d < 6; d++) add_step(4, 1, op_read, d, 0, 0, 0, 2, '0);
        timeout_lim = tbl.size() * 128;        // longest step stays well below this

        repeat (4) @(posedge adc_clk);
        #1;
        rst = 1'b0;
        check_val("armed", armed, 0);
        check_val("done", done, 0);
        check_val("rd_valid", rd_valid, 0);

        cur = 1;
        foreach (tbl[i]) begin
            if (tbl[i].test != cur) begin
                finish_test(cur);
                cur = tbl[i].test;
            end
            run_cycle(tbl[i].cv, tbl[i].op, tbl[i].arg, tbl[i].tg, tbl[i].chk, tbl[i].exp);
            repeat (tbl[i].idle) run_cycle(0, op_mode, 0, 0, 0, '0);
            if (tbl[i].wait_done) begin
                while (!done) run_cycle(0, op_mode, 0, 0, 0, '0);
            end
        end
        finish_test(cur);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
